/* common/tlb_pkg.sv */
package tlb_pkg;

    // field widths
    localparam int VPPN_W   = 19;
    localparam int ASID_W   = 10;
    localparam int PPN_W    = 20;
    localparam int PLV_W    = 2;
    localparam int MAT_W    = 2;
    localparam int PS_W     = 6;
    localparam int INV_OP_W = 5;

    // page size codes, log2 of the page size in bytes
    localparam logic [PS_W-1:0] PS_4K = 6'd12;
    localparam logic [PS_W-1:0] PS_4M = 6'd21;

    // invtlb op codes
    localparam logic [INV_OP_W-1:0] INV_ALL0              = 5'd0;
    localparam logic [INV_OP_W-1:0] INV_ALL1              = 5'd1;
    localparam logic [INV_OP_W-1:0] INV_GLOBAL            = 5'd2;
    localparam logic [INV_OP_W-1:0] INV_NONGLOBAL         = 5'd3;
    localparam logic [INV_OP_W-1:0] INV_ASID              = 5'd4;
    localparam logic [INV_OP_W-1:0] INV_ASID_VA           = 5'd5;
    localparam logic [INV_OP_W-1:0] INV_GLOBAL_OR_ASID_VA = 5'd6;

    // 4 MB view of a vppn word
    typedef struct packed {
        logic [9:0] vpn_hi;
        logic       odd;
        logic [7:0] rsvd;
    } vppn_4m_t;

    // one vppn word, read as a flat 4 KB pair number or as a 4 MB page
    typedef union packed {
        logic [VPPN_W-1:0] view_4k;
        vppn_4m_t          view_4m;
    } vppn_t;

endpackage

/* lookup/tlb_match.sv */
`timescale 1ns/100ps

module tlb_match #(
    parameter int TLB_NUM = 16,
    localparam int IDX_W = $clog2(TLB_NUM)
) (
    input  tlb_pkg::vppn_t                           key_vppn,
    input  logic [tlb_pkg::ASID_W-1:0]               key_asid,
    input  logic [TLB_NUM-1:0]                       ent_e,
    input  logic [TLB_NUM-1:0]                       ent_g,
    input  logic [TLB_NUM-1:0]                       ent_ps4m,
    input  logic [TLB_NUM-1:0][tlb_pkg::ASID_W-1:0]  ent_asid,
    input  tlb_pkg::vppn_t [TLB_NUM-1:0]             ent_vppn,
    output logic                                     found,
    output logic [IDX_W-1:0]                         index
);
    import tlb_pkg::*;

    logic [TLB_NUM-1:0] hit;

    // low 9 bits only count for 4 KB entries
    always_comb begin
        for (int i = 0; i < TLB_NUM; i++) begin
            hit[i] = ent_e[i]
                && (key_vppn.view_4m.vpn_hi == ent_vppn[i].view_4m.vpn_hi)
                && (ent_ps4m[i] || key_vppn.view_4k[8:0] == ent_vppn[i].view_4k[8:0])
                && (ent_g[i] || key_asid == ent_asid[i]);
        end
    end

    assign found = |hit;

    // or-encode, valid while hits stay unique
    always_comb begin
        index = '0;
        for (int i = 0; i < TLB_NUM; i++) begin
            if (hit[i])
                index = index | IDX_W'(i);
        end
    end

    // software must never install overlapping entries
    always_comb begin
        a_hit_unique: assert final ($onehot0(hit));
    end

endmodule

/* lookup/tlb_page_select.sv */
`timescale 1ns/100ps

module tlb_page_select #(
    parameter int TLB_NUM = 16,
    localparam int IDX_W = $clog2(TLB_NUM)
) (
    input  logic                                    found,
    input  logic [IDX_W-1:0]                        index,
    input  tlb_pkg::vppn_t                          key_vppn,
    input  logic                                    va_bit12,
    input  logic [TLB_NUM-1:0]                      ent_ps4m,
    input  logic [TLB_NUM-1:0][tlb_pkg::PPN_W-1:0]  ent_ppn0,
    input  logic [TLB_NUM-1:0][tlb_pkg::PLV_W-1:0]  ent_plv0,
    input  logic [TLB_NUM-1:0][tlb_pkg::MAT_W-1:0]  ent_mat0,
    input  logic [TLB_NUM-1:0]                      ent_d0,
    input  logic [TLB_NUM-1:0]                      ent_v0,
    input  logic [TLB_NUM-1:0][tlb_pkg::PPN_W-1:0]  ent_ppn1,
    input  logic [TLB_NUM-1:0][tlb_pkg::PLV_W-1:0]  ent_plv1,
    input  logic [TLB_NUM-1:0][tlb_pkg::MAT_W-1:0]  ent_mat1,
    input  logic [TLB_NUM-1:0]                      ent_d1,
    input  logic [TLB_NUM-1:0]                      ent_v1,
    output logic [tlb_pkg::PPN_W-1:0]               ppn,
    output logic [tlb_pkg::PS_W-1:0]                ps,
    output logic [tlb_pkg::PLV_W-1:0]               plv,
    output logic [tlb_pkg::MAT_W-1:0]               mat,
    output logic                                    d,
    output logic                                    v
);
    import tlb_pkg::*;

    logic hit_4m;
    logic odd;

    assign hit_4m = ent_ps4m[index];
    // 4 MB pages split on vppn bit 8, 4 KB pairs on va bit 12
    assign odd = hit_4m ? key_vppn.view_4m.odd : va_bit12;

    always_comb begin
        ppn = '0;
        ps  = '0;
        plv = '0;
        mat = '0;
        d   = 1'b0;
        v   = 1'b0;
        if (found) begin
            ps  = hit_4m ? PS_4M : PS_4K;
            ppn = odd ? ent_ppn1[index] : ent_ppn0[index];
            plv = odd ? ent_plv1[index] : ent_plv0[index];
            mat = odd ? ent_mat1[index] : ent_mat0[index];
            d   = odd ? ent_d1[index] : ent_d0[index];
            v   = odd ? ent_v1[index] : ent_v0[index];
        end
    end

endmodule

/* src/tlb_maint_ctrl.sv */
`timescale 1ns/100ps

module tlb_maint_ctrl #(
    parameter int TLB_NUM = 16,
    localparam int IDX_W = $clog2(TLB_NUM)
) (
    input  logic                                     clk,
    input  logic                                     rst,
    input  logic                                     invtlb_valid,
    input  logic [tlb_pkg::INV_OP_W-1:0]             invtlb_op,
    input  logic [tlb_pkg::ASID_W-1:0]               invtlb_asid,
    input  tlb_pkg::vppn_t                           invtlb_va,
    input  logic                                     we,
    input  logic [IDX_W-1:0]                         w_index,
    input  logic [TLB_NUM-1:0]                       ent_g,
    input  logic [TLB_NUM-1:0][tlb_pkg::ASID_W-1:0]  ent_asid,
    input  tlb_pkg::vppn_t [TLB_NUM-1:0]             ent_vppn,
    output logic [TLB_NUM-1:0]                       e_clear,
    output logic [TLB_NUM-1:0]                       e_write,
    output logic                                     e_keep_w
);
    import tlb_pkg::*;

    logic [TLB_NUM-1:0] asid_eq;
    logic [TLB_NUM-1:0] va_eq;

    always_comb begin
        for (int i = 0; i < TLB_NUM; i++) begin
            asid_eq[i] = (ent_asid[i] == invtlb_asid);
            va_eq[i]   = (ent_vppn[i].view_4k == invtlb_va.view_4k);
        end
    end

    // per-entry clear mask for the current op
    always_comb begin
        e_clear = '0;
        if (invtlb_valid) begin
            case (invtlb_op)
                INV_ALL0, INV_ALL1:    e_clear = '1;
                INV_GLOBAL:            e_clear = ent_g;
                INV_NONGLOBAL:         e_clear = ~ent_g;
                INV_ASID:              e_clear = ~ent_g & asid_eq;
                INV_ASID_VA:           e_clear = ~ent_g & asid_eq & va_eq;
                INV_GLOBAL_OR_ASID_VA: e_clear = (ent_g | asid_eq) & va_eq;
                default:               e_clear = '0;
            endcase
        end
    end

    // one-hot write enable
    always_comb begin
        e_write = '0;
        if (we)
            e_write[w_index] = 1'b1;
    end

    // a same-cycle invalidate owns the valid bit
    assign e_keep_w = ~invtlb_valid;

    a_op_legal: assert property (@(posedge clk) disable iff (rst)
        invtlb_valid |-> invtlb_op <= INV_GLOBAL_OR_ASID_VA);

endmodule

/* src/tlb_entry_array.sv */
`timescale 1ns/100ps

module tlb_entry_array #(
    parameter int TLB_NUM = 16,
    localparam int IDX_W = $clog2(TLB_NUM)
) (
    input  logic                                     clk,
    input  logic                                     rst,
    input  logic [TLB_NUM-1:0]                       e_clear,
    input  logic [TLB_NUM-1:0]                       e_write,
    input  logic                                     e_keep_w,
    input  logic                                     w_e,
    input  logic [tlb_pkg::VPPN_W-1:0]               w_vppn,
    input  logic [tlb_pkg::PS_W-1:0]                 w_ps,
    input  logic [tlb_pkg::ASID_W-1:0]               w_asid,
    input  logic                                     w_g,
    input  logic [tlb_pkg::PPN_W-1:0]                w_ppn0,
    input  logic [tlb_pkg::PLV_W-1:0]                w_plv0,
    input  logic [tlb_pkg::MAT_W-1:0]                w_mat0,
    input  logic                                     w_d0,
    input  logic                                     w_v0,
    input  logic [tlb_pkg::PPN_W-1:0]                w_ppn1,
    input  logic [tlb_pkg::PLV_W-1:0]                w_plv1,
    input  logic [tlb_pkg::MAT_W-1:0]                w_mat1,
    input  logic                                     w_d1,
    input  logic                                     w_v1,
    input  logic [IDX_W-1:0]                         r_index,
    output logic [TLB_NUM-1:0]                       ent_e,
    output logic [TLB_NUM-1:0]                       ent_g,
    output logic [TLB_NUM-1:0]                       ent_ps4m,
    output logic [TLB_NUM-1:0][tlb_pkg::ASID_W-1:0]  ent_asid,
    output tlb_pkg::vppn_t [TLB_NUM-1:0]             ent_vppn,
    output logic [TLB_NUM-1:0][tlb_pkg::PPN_W-1:0]   ent_ppn0,
    output logic [TLB_NUM-1:0][tlb_pkg::PLV_W-1:0]   ent_plv0,
    output logic [TLB_NUM-1:0][tlb_pkg::MAT_W-1:0]   ent_mat0,
    output logic [TLB_NUM-1:0]                       ent_d0,
    output logic [TLB_NUM-1:0]                       ent_v0,
    output logic [TLB_NUM-1:0][tlb_pkg::PPN_W-1:0]   ent_ppn1,
    output logic [TLB_NUM-1:0][tlb_pkg::PLV_W-1:0]   ent_plv1,
    output logic [TLB_NUM-1:0][tlb_pkg::MAT_W-1:0]   ent_mat1,
    output logic [TLB_NUM-1:0]                       ent_d1,
    output logic [TLB_NUM-1:0]                       ent_v1,
    output logic                                     r_e,
    output logic [tlb_pkg::VPPN_W-1:0]               r_vppn,
    output logic [tlb_pkg::PS_W-1:0]                 r_ps,
    output logic [tlb_pkg::ASID_W-1:0]               r_asid,
    output logic                                     r_g,
    output logic [tlb_pkg::PPN_W-1:0]                r_ppn0,
    output logic [tlb_pkg::PLV_W-1:0]                r_plv0,
    output logic [tlb_pkg::MAT_W-1:0]                r_mat0,
    output logic                                     r_d0,
    output logic                                     r_v0,
    output logic [tlb_pkg::PPN_W-1:0]                r_ppn1,
    output logic [tlb_pkg::PLV_W-1:0]                r_plv1,
    output logic [tlb_pkg::MAT_W-1:0]                r_mat1,
    output logic                                     r_d1,
    output logic                                     r_v1
);
    import tlb_pkg::*;

    // valid bits, invalidate has priority over the write
    always_ff @(posedge clk) begin
        if (rst) begin
            ent_e <= '0;
        end else begin
            for (int i = 0; i < TLB_NUM; i++) begin
                if (e_write[i] && e_keep_w)
                    ent_e[i] <= w_e;
                else if (e_clear[i])
                    ent_e[i] <= 1'b0;
            end
        end
    end

    // entry fields, page size kept as one 4 MB flag
    always_ff @(posedge clk) begin
        if (rst) begin
            ent_g    <= '0;
            ent_ps4m <= '0;
            ent_asid <= '0;
            ent_vppn <= '0;
            ent_ppn0 <= '0;
            ent_plv0 <= '0;
            ent_mat0 <= '0;
            ent_d0   <= '0;
            ent_v0   <= '0;
            ent_ppn1 <= '0;
            ent_plv1 <= '0;
            ent_mat1 <= '0;
            ent_d1   <= '0;
            ent_v1   <= '0;
        end else begin
            for (int i = 0; i < TLB_NUM; i++) begin
                if (e_write[i]) begin
                    ent_g[i]    <= w_g;
                    ent_ps4m[i] <= (w_ps == PS_4M);
                    ent_asid[i] <= w_asid;
                    ent_vppn[i] <= w_vppn;
                    ent_ppn0[i] <= w_ppn0;
                    ent_plv0[i] <= w_plv0;
                    ent_mat0[i] <= w_mat0;
                    ent_d0[i]   <= w_d0;
                    ent_v0[i]   <= w_v0;
                    ent_ppn1[i] <= w_ppn1;
                    ent_plv1[i] <= w_plv1;
                    ent_mat1[i] <= w_mat1;
                    ent_d1[i]   <= w_d1;
                    ent_v1[i]   <= w_v1;
                end
            end
        end
    end

    // read port
    assign r_e    = ent_e[r_index];
    assign r_vppn = ent_vppn[r_index];
    assign r_ps   = ent_ps4m[r_index] ? PS_4M : PS_4K;
    assign r_asid = ent_asid[r_index];
    assign r_g    = ent_g[r_index];
    assign r_ppn0 = ent_ppn0[r_index];
    assign r_plv0 = ent_plv0[r_index];
    assign r_mat0 = ent_mat0[r_index];
    assign r_d0   = ent_d0[r_index];
    assign r_v0   = ent_v0[r_index];
    assign r_ppn1 = ent_ppn1[r_index];
    assign r_plv1 = ent_plv1[r_index];
    assign r_mat1 = ent_mat1[r_index];
    assign r_d1   = ent_d1[r_index];
    assign r_v1   = ent_v1[r_index];

    // only the two supported page sizes may be stored
    a_ps_legal: assert property (@(posedge clk) disable iff (rst)
        |e_write |-> (w_ps == PS_4K || w_ps == PS_4M));

endmodule

/* src/tlb_top.sv */
`timescale 1ns/100ps

module tlb_top #(
    parameter int TLB_NUM = 16,
    localparam int IDX_W = $clog2(TLB_NUM)
) (
    input  logic                          clk,
    input  logic                          rst,
    // translation port
    input  tlb_pkg::vppn_t                s0_vppn,
    input  logic                          s0_va_bit12,
    input  logic [tlb_pkg::ASID_W-1:0]    s0_asid,
    output logic                          s0_found,
    output logic [IDX_W-1:0]              s0_index,
    output logic [tlb_pkg::PPN_W-1:0]     s0_ppn,
    output logic [tlb_pkg::PS_W-1:0]      s0_ps,
    output logic [tlb_pkg::PLV_W-1:0]     s0_plv,
    output logic [tlb_pkg::MAT_W-1:0]     s0_mat,
    output logic                          s0_d,
    output logic                          s0_v,
    // invtlb
    input  logic                          invtlb_valid,
    input  logic [tlb_pkg::INV_OP_W-1:0]  invtlb_op,
    input  logic [tlb_pkg::ASID_W-1:0]    invtlb_asid,
    input  tlb_pkg::vppn_t                invtlb_va,
    // write port
    input  logic                          we,
    input  logic [IDX_W-1:0]              w_index,
    input  logic                          w_e,
    input  logic [tlb_pkg::VPPN_W-1:0]    w_vppn,
    input  logic [tlb_pkg::PS_W-1:0]      w_ps,
    input  logic [tlb_pkg::ASID_W-1:0]    w_asid,
    input  logic                          w_g,
    input  logic [tlb_pkg::PPN_W-1:0]     w_ppn0,
    input  logic [tlb_pkg::PLV_W-1:0]     w_plv0,
    input  logic [tlb_pkg::MAT_W-1:0]     w_mat0,
    input  logic                          w_d0,
    input  logic                          w_v0,
    input  logic [tlb_pkg::PPN_W-1:0]     w_ppn1,
    input  logic [tlb_pkg::PLV_W-1:0]     w_plv1,
    input  logic [tlb_pkg::MAT_W-1:0]     w_mat1,
    input  logic                          w_d1,
    input  logic                          w_v1,
    // read port
    input  logic [IDX_W-1:0]              r_index,
    output logic                          r_e,
    output logic [tlb_pkg::VPPN_W-1:0]    r_vppn,
    output logic [tlb_pkg::PS_W-1:0]      r_ps,
    output logic [tlb_pkg::ASID_W-1:0]    r_asid,
    output logic                          r_g,
    output logic [tlb_pkg::PPN_W-1:0]     r_ppn0,
    output logic [tlb_pkg::PLV_W-1:0]     r_plv0,
    output logic [tlb_pkg::MAT_W-1:0]     r_mat0,
    output logic                          r_d0,
    output logic                          r_v0,
    output logic [tlb_pkg::PPN_W-1:0]     r_ppn1,
    output logic [tlb_pkg::PLV_W-1:0]     r_plv1,
    output logic [tlb_pkg::MAT_W-1:0]     r_mat1,
    output logic                          r_d1,
    output logic                          r_v1,
    // tlbsrch
    input  tlb_pkg::vppn_t                srch_vppn,
    input  logic [tlb_pkg::ASID_W-1:0]    srch_asid,
    output logic                          srch_found,
    output logic [IDX_W-1:0]              srch_index
);
    import tlb_pkg::*;

    logic [TLB_NUM-1:0]             e_clear;
    logic [TLB_NUM-1:0]             e_write;
    logic                           e_keep_w;
    logic [TLB_NUM-1:0]             ent_e;
    logic [TLB_NUM-1:0]             ent_g;
    logic [TLB_NUM-1:0]             ent_ps4m;
    logic [TLB_NUM-1:0][ASID_W-1:0] ent_asid;
    vppn_t [TLB_NUM-1:0]            ent_vppn;
    logic [TLB_NUM-1:0][PPN_W-1:0]  ent_ppn0;
    logic [TLB_NUM-1:0][PLV_W-1:0]  ent_plv0;
    logic [TLB_NUM-1:0][MAT_W-1:0]  ent_mat0;
    logic [TLB_NUM-1:0]             ent_d0;
    logic [TLB_NUM-1:0]             ent_v0;
    logic [TLB_NUM-1:0][PPN_W-1:0]  ent_ppn1;
    logic [TLB_NUM-1:0][PLV_W-1:0]  ent_plv1;
    logic [TLB_NUM-1:0][MAT_W-1:0]  ent_mat1;
    logic [TLB_NUM-1:0]             ent_d1;
    logic [TLB_NUM-1:0]             ent_v1;

    tlb_maint_ctrl #(.TLB_NUM(TLB_NUM)) u_maint_ctrl (
        .clk(clk), .rst(rst),
        .invtlb_valid(invtlb_valid), .invtlb_op(invtlb_op),
        .invtlb_asid(invtlb_asid), .invtlb_va(invtlb_va),
        .we(we), .w_index(w_index),
        .ent_g(ent_g), .ent_asid(ent_asid), .ent_vppn(ent_vppn),
        .e_clear(e_clear), .e_write(e_write), .e_keep_w(e_keep_w)
    );

    tlb_entry_array #(.TLB_NUM(TLB_NUM)) u_entry_array (
        .clk(clk), .rst(rst),
        .e_clear(e_clear), .e_write(e_write), .e_keep_w(e_keep_w),
        .w_e(w_e), .w_vppn(w_vppn), .w_ps(w_ps), .w_asid(w_asid), .w_g(w_g),
        .w_ppn0(w_ppn0), .w_plv0(w_plv0), .w_mat0(w_mat0), .w_d0(w_d0), .w_v0(w_v0),
        .w_ppn1(w_ppn1), .w_plv1(w_plv1), .w_mat1(w_mat1), .w_d1(w_d1), .w_v1(w_v1),
        .r_index(r_index),
        .ent_e(ent_e), .ent_g(ent_g), .ent_ps4m(ent_ps4m),
        .ent_asid(ent_asid), .ent_vppn(ent_vppn),
        .ent_ppn0(ent_ppn0), .ent_plv0(ent_plv0), .ent_mat0(ent_mat0),
        .ent_d0(ent_d0), .ent_v0(ent_v0),
        .ent_ppn1(ent_ppn1), .ent_plv1(ent_plv1), .ent_mat1(ent_mat1),
        .ent_d1(ent_d1), .ent_v1(ent_v1),
        .r_e(r_e), .r_vppn(r_vppn), .r_ps(r_ps), .r_asid(r_asid), .r_g(r_g),
        .r_ppn0(r_ppn0), .r_plv0(r_plv0), .r_mat0(r_mat0), .r_d0(r_d0), .r_v0(r_v0),
        .r_ppn1(r_ppn1), .r_plv1(r_plv1), .r_mat1(r_mat1), .r_d1(r_d1), .r_v1(r_v1)
    );

    tlb_match #(.TLB_NUM(TLB_NUM)) u_match_s0 (
        .key_vppn(s0_vppn), .key_asid(s0_asid),
        .ent_e(ent_e), .ent_g(ent_g), .ent_ps4m(ent_ps4m),
        .ent_asid(ent_asid), .ent_vppn(ent_vppn),
        .found(s0_found), .index(s0_index)
    );

    tlb_match #(.TLB_NUM(TLB_NUM)) u_match_srch (
        .key_vppn(srch_vppn), .key_asid(srch_asid),
        .ent_e(ent_e), .ent_g(ent_g), .ent_ps4m(ent_ps4m),
        .ent_asid(ent_asid), .ent_vppn(ent_vppn),
        .found(srch_found), .index(srch_index)
    );

    tlb_page_select #(.TLB_NUM(TLB_NUM)) u_page_select (
        .found(s0_found), .index(s0_index),
        .key_vppn(s0_vppn), .va_bit12(s0_va_bit12), .ent_ps4m(ent_ps4m),
        .ent_ppn0(ent_ppn0), .ent_plv0(ent_plv0), .ent_mat0(ent_mat0),
        .ent_d0(ent_d0), .ent_v0(ent_v0),
        .ent_ppn1(ent_ppn1), .ent_plv1(ent_plv1), .ent_mat1(ent_mat1),
        .ent_d1(ent_d1), .ent_v1(ent_v1),
        .ppn(s0_ppn), .ps(s0_ps), .plv(s0_plv), .mat(s0_mat), .d(s0_d), .v(s0_v)
    );

endmodule

/* verification/tb_clk_gen.sv */
`timescale 1ns/100ps

module tb_clk_gen #(
    parameter int PERIOD = 10,
    parameter int RESET_CYCLES = 4
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // release lines up with the testbench drive point
    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #1 rst = 1'b0;
    end

endmodule

/* verification/tb_tlb.sv */
`timescale 1ns/100ps

module tb_tlb;
    import tlb_pkg::*;

    localparam int TLB_NUM = 16;
    localparam int CLK_PERIOD = 10;
    localparam int NUM_TESTS = 6;
    localparam int CYCLES_PER_TEST = 200;

    logic clk, rst;
    vppn_t s0_vppn, invtlb_va, srch_vppn;
    logic s0_va_bit12, s0_found, s0_d, s0_v, invtlb_valid, we, w_e, w_g;
    logic w_d0, w_v0, w_d1, w_v1, r_e, r_g, r_d0, r_v0, r_d1, r_v1, srch_found;
    logic [3:0] s0_index, w_index, r_index, srch_index;
    logic [ASID_W-1:0] s0_asid, invtlb_asid, w_asid, r_asid, srch_asid;
    logic [PPN_W-1:0] s0_ppn, w_ppn0, w_ppn1, r_ppn0, r_ppn1;
    logic [PS_W-1:0] s0_ps, w_ps, r_ps;
    logic [PLV_W-1:0] s0_plv, w_plv0, w_plv1, r_plv0, r_plv1;
    logic [MAT_W-1:0] s0_mat, w_mat0, w_mat1, r_mat0, r_mat1;
    logic [INV_OP_W-1:0] invtlb_op;
    logic [VPPN_W-1:0] w_vppn, r_vppn;

    // reference model, page fields packed as {ppn, plv, mat, d, v}
    logic m_e [TLB_NUM];
    logic m_g [TLB_NUM];
    logic m_ps4m [TLB_NUM];
    logic [VPPN_W-1:0] m_vppn [TLB_NUM];
    logic [ASID_W-1:0] m_asid [TLB_NUM];
    logic [25:0] m_pg0 [TLB_NUM];
    logic [25:0] m_pg1 [TLB_NUM];
    integer seed = 6;

    tb_clk_gen #(.PERIOD(CLK_PERIOD), .RESET_CYCLES(4)) u_clk_gen (.clk(clk), .rst(rst));

    tlb_top #(.TLB_NUM(TLB_NUM)) uut (.*);

    task automatic expect_equal(input string name, input logic [63:0] expected,
                                input logic [63:0] actual);
        assert (expected === actual) else begin
            $display("Fail %s expected %0h actual %0h", name, expected, actual);
            $display("TESTS FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    // a miss must leave every page output at zero
    a_miss_zero: assert property (@(posedge clk) disable iff (rst)
        !s0_found |-> {s0_ppn, s0_ps, s0_plv, s0_mat, s0_d, s0_v} == '0)
        else begin
            $display("Fail translate miss expected 0 actual %0h",
                     {s0_ppn, s0_ps, s0_plv, s0_mat, s0_d, s0_v});
            $display("TESTS FAILED");
            $fatal(1, "miss outputs not zero");
        end

    task automatic next_drive;
        @(posedge clk);
        #1;
    endtask

    function automatic logic inv_selects(input int op, input int i, input logic [9:0] asid,
                                         input logic [18:0] va);
        logic asid_eq;
        logic va_eq;
        asid_eq = (m_asid[i] == asid);
        va_eq = (m_vppn[i] == va);
        case (op)
            0, 1: return 1'b1;
            2: return m_g[i];
            3: return !m_g[i];
            4: return !m_g[i] && asid_eq;
            5: return !m_g[i] && asid_eq && va_eq;
            default: return (m_g[i] || asid_eq) && va_eq;
        endcase
    endfunction

    task automatic set_write(input int idx, input logic e);
        logic [31:0] rnd;
        rnd = $random(seed);
        we = 1'b1;
        w_index = idx[3:0];
        w_e = e;
        // idx in the high part keeps every vpn_hi distinct
        w_vppn = {rnd[5:0], idx[3:0], rnd[14:6]};
        w_asid = {8'h15, rnd[16:15]};
        w_ps = idx[0] ? PS_4M : PS_4K;
        w_g = (idx % 3 == 0);
        rnd = $random(seed);
        {w_ppn0, w_plv0, w_mat0, w_d0, w_v0} = rnd[25:0];
        rnd = $random(seed);
        {w_ppn1, w_plv1, w_mat1, w_d1, w_v1} = rnd[25:0];
    endtask

    // one clock with the current strobes, model follows the same edge
    task automatic commit;
        logic clr [TLB_NUM];
        for (int i = 0; i < TLB_NUM; i++)
            clr[i] = invtlb_valid && inv_selects(invtlb_op, i, invtlb_asid, invtlb_va);
        @(posedge clk);
        for (int i = 0; i < TLB_NUM; i++)
            if (clr[i])
                m_e[i] = 1'b0;
        if (we) begin
            m_vppn[w_index] = w_vppn;
            m_asid[w_index] = w_asid;
            m_g[w_index] = w_g;
            m_ps4m[w_index] = (w_ps == PS_4M);
            m_pg0[w_index] = {w_ppn0, w_plv0, w_mat0, w_d0, w_v0};
            m_pg1[w_index] = {w_ppn1, w_plv1, w_mat1, w_d1, w_v1};
            if (!invtlb_valid)
                m_e[w_index] = w_e;
        end
        #1;
        we = 1'b0;
        invtlb_valid = 1'b0;
    endtask

    task automatic fill_all;
        for (int i = 0; i < TLB_NUM; i++) begin
            set_write(i, 1'b1);
            commit();
        end
    endtask

    task automatic check_valid_bits(input string name);
        for (int i = 0; i < TLB_NUM; i++) begin
            r_index = i[3:0];
            #1;
            expect_equal({name, " r_e"}, m_e[i], r_e);
            next_drive();
        end
    endtask

    task automatic check_entry(input string name, input int i);
        r_index = i[3:0];
        #1;
        expect_equal({name, " r_e"}, m_e[i], r_e);
        expect_equal({name, " r_vppn"}, m_vppn[i], r_vppn);
        expect_equal({name, " r_ps"}, m_ps4m[i] ? 6'd21 : 6'd12, r_ps);
        expect_equal({name, " r_asid"}, m_asid[i], r_asid);
        expect_equal({name, " r_g"}, m_g[i], r_g);
        expect_equal({name, " page0"}, m_pg0[i], {r_ppn0, r_plv0, r_mat0, r_d0, r_v0});
        expect_equal({name, " page1"}, m_pg1[i], {r_ppn1, r_plv1, r_mat1, r_d1, r_v1});
        next_drive();
    endtask

    task automatic lookup(input string name, input logic [18:0] vppn, input logic bit12,
                          input logic [9:0] asid);
        logic exp_found;
        logic odd;
        int exp_idx;
        logic [25:0] pg;
        s0_vppn = vppn;
        s0_va_bit12 = bit12;
        s0_asid = asid;
        srch_vppn = vppn;
        srch_asid = asid;
        exp_found = 1'b0;
        exp_idx = 0;
        for (int i = 0; i < TLB_NUM; i++) begin
            if (m_e[i] && vppn[18:9] == m_vppn[i][18:9]
                    && (m_ps4m[i] || vppn[8:0] == m_vppn[i][8:0])
                    && (m_g[i] || asid == m_asid[i])) begin
                exp_found = 1'b1;
                exp_idx = i;
            end
        end
        #1;
        expect_equal({name, " s0_found"}, exp_found, s0_found);
        expect_equal({name, " srch_found"}, exp_found, srch_found);
        if (exp_found) begin
            odd = m_ps4m[exp_idx] ? vppn[8] : bit12;
            pg = odd ? m_pg1[exp_idx] : m_pg0[exp_idx];
            expect_equal({name, " s0_index"}, exp_idx, s0_index);
            expect_equal({name, " srch_index"}, exp_idx, srch_index);
            expect_equal({name, " s0_ps"}, m_ps4m[exp_idx] ? 6'd21 : 6'd12, s0_ps);
            expect_equal({name, " page"}, pg, {s0_ppn, s0_plv, s0_mat, s0_d, s0_v});
        end
        next_drive();
    endtask

    initial begin
        #(NUM_TESTS * CYCLES_PER_TEST * CLK_PERIOD);
        $display("Watchdog timeout, the tests did not finish in time");
        $display("TESTS FAILED");
        $fatal(1, "timeout");
    end

    initial begin
        logic [18:0] key;
        logic [31:0] rnd;
        int k;
        s0_vppn = '0;
        s0_va_bit12 = 1'b0;
        s0_asid = '0;
        invtlb_valid = 1'b0;
        invtlb_op = '0;
        invtlb_asid = '0;
        invtlb_va = '0;
        we = 1'b0;
        w_index = '0;
        w_e = 1'b0;
        w_vppn = '0;
        w_ps = PS_4K;
        w_asid = '0;
        w_g = 1'b0;
        {w_ppn0, w_plv0, w_mat0, w_d0, w_v0} = '0;
        {w_ppn1, w_plv1, w_mat1, w_d1, w_v1} = '0;
        r_index = '0;
        srch_vppn = '0;
        srch_asid = '0;
        for (int i = 0; i < TLB_NUM; i++) begin
            m_e[i] = 1'b0;
            m_g[i] = 1'b0;
            m_ps4m[i] = 1'b0;
            m_vppn[i] = '0;
            m_asid[i] = '0;
            m_pg0[i] = '0;
            m_pg1[i] = '0;
        end
        wait (rst == 1'b0);

        check_valid_bits("reset");
        lookup("reset lookup", '0, 1'b0, '0);

        fill_all();
        for (int i = 0; i < TLB_NUM; i++)
            check_entry("write readback", i);

        // odd i are 4 MB entries
        // their page comes from key bit 8, so va bit 12 is set opposite
        for (int i = 0; i < TLB_NUM; i++) begin
            rnd = $random(seed);
            key = m_vppn[i];
            if (m_ps4m[i])
                key[8:0] = {i[1], rnd[7:0]};
            lookup("translate", key, m_ps4m[i] ? !i[1] : i[1], m_asid[i]);
            lookup("translate wrong asid", key, rnd[9], m_asid[i] ^ 10'h200);
        end

        for (int j = 0; j < 24; j++) begin
            rnd = $random(seed);
            if (j % 2 == 0)
                lookup("search", m_vppn[rnd[3:0]], rnd[4], {8'h15, rnd[6:5]});
            else
                lookup("search random", rnd[18:0], rnd[19], rnd[29:20]);
        end

        // entry op is non-global for op 5 and global for op 6
        for (int op = 0; op < 7; op++) begin
            fill_all();
            invtlb_valid = 1'b1;
            invtlb_op = op[4:0];
            invtlb_asid = m_asid[op];
            invtlb_va = m_vppn[op];
            commit();
            check_valid_bits($sformatf("invtlb op %0d", op));
        end

        for (int c = 0; c < 2; c++) begin
            fill_all();
            k = c + 1;
            invtlb_valid = 1'b1;
            invtlb_op = (c == 0) ? INV_ALL0 : INV_GLOBAL;
            invtlb_asid = m_asid[0];
            invtlb_va = m_vppn[0];
            set_write(k, c == 0);
            commit();
            check_entry("invtlb with write", k);
            check_valid_bits("invtlb with write");
        end

        $display("TESTS PASSED");
        $finish;
    end

endmodule

/* filelist.f */
common/tlb_pkg.sv
lookup/tlb_match.sv
lookup/tlb_page_select.sv
src/tlb_maint_ctrl.sv
src/tlb_entry_array.sv
src/tlb_top.sv
verification/tb_clk_gen.sv
verification/tb_tlb.sv
